//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --assert -j 0
TOP       = tb_analog_core
FILE_LIST = compile.f
OBJ_DIR   = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
verilog/acore_pkg.sv
verilog/input_divider.sv
verilog/phase_interpolator.sv
verilog/snh.sv
verilog/slice_adc.sv
verilog/analog_core.sv
test/tb_analog_core.sv

//--- test/tb_analog_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_analog_core import acore_pkg::*; ();

    localparam int NTI         = 8;
    localparam int TIMEOUT_CYC = 4000;      // about twice the longest run
    localparam int MAG_MAX     = (1 << Nadc) - 1;

    logic           ext_clk;
    logic           rst;
    sample_t        rx_in;
    sample_t        offset;
    ndiv_t          ndiv;
    logic           bypass_div;
    logic           en_div;
    pi_code_t       ctl_pi;
    logic           ctl_valid;
    logic           en_v2t;
    logic [NTI-1:0] en_slice;
    mag_t           adder_out [NTI-1:0];
    logic [NTI-1:0] sign_out;
    logic [NTI-1:0] done;

    int    seed = 32'h193b8280;
    int    cyc_cnt = 0;
    string phase_name = "reset";

    // stimulus side of the reference model
    logic           ramp_on;
    logic           clr_model;
    logic           chk_seq;        // slot order and ramp step checks active
    logic           const_mode;
    logic [NTI-1:0] allow_mask;     // slices that may report a conversion
    int             exp_step;
    int             pend_model;
    int             exp_mag;
    logic           exp_sign;

    // observed side, updated on every done pulse
    logic have_prev;
    int   conv_count;
    int   prev_val;
    int   prev_slot;
    int   first_slot;
    int   last_slot;
    int   act_model;

    logic conv_any;
    int   conv_slot;
    int   conv_val;
    int   code_delta;
    mag_t conv_mag;
    logic conv_sign;
    mag_t adder_or;

    analog_core #(.Nti(NTI)) analog_core_inst (
        .ext_clk_i    (ext_clk),
        .rst_i        (rst),
        .rx_in_i      (rx_in),
        .offset_i     (offset),
        .ndiv_i       (ndiv),
        .bypass_div_i (bypass_div),
        .en_div_i     (en_div),
        .ctl_pi_i     (ctl_pi),
        .ctl_valid_i  (ctl_valid),
        .en_v2t_i     (en_v2t),
        .en_slice_i   (en_slice),
        .adder_out_o  (adder_out),
        .sign_out_o   (sign_out),
        .done_o       (done)
    );

    always #50 ext_clk = ~ext_clk;

    always @(posedge ext_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TEST FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    // decode the one slice that finished this cycle
    always_comb begin
        conv_slot = 0;
        conv_mag  = '0;
        conv_sign = 1'b0;
        adder_or  = '0;
        for (int k = 0; k < NTI; k++) begin
            adder_or = adder_or | adder_out[k];
            if (done[k]) begin
                conv_slot = k;
                conv_mag  = adder_out[k];
                conv_sign = sign_out[k];
            end
        end
        conv_any   = |done;
        conv_val   = conv_sign ? int'(offset) + int'(conv_mag) : int'(offset) - int'(conv_mag);
        code_delta = (conv_slot == 0) ? pend_model - act_model : 0;  // new code starts a frame
    end

    always @(posedge ext_clk) begin
        if (rst) begin
            have_prev  <= 1'b0;
            conv_count <= 0;
            act_model  <= 0;
        end else if (clr_model) begin
            have_prev <= 1'b0;
        end else if (conv_any) begin
            have_prev  <= 1'b1;
            prev_val   <= conv_val;
            prev_slot  <= conv_slot;
            last_slot  <= conv_slot;
            conv_count <= conv_count + 1;
            if (!have_prev)
                first_slot <= conv_slot;
            if (conv_slot == 0)
                act_model <= pend_model;
        end
    end

    a_reset_quiet: assert property (@(posedge ext_clk)
        (cyc_cnt >= 1 && cyc_cnt <= 6) |-> ({done, sign_out, adder_or} == '0)
    ) else report_error("reset", 0, int'($sampled({done, sign_out, adder_or})));

    a_enable_mask: assert property (@(posedge ext_clk) disable iff (rst)
        (done & ~allow_mask) == '0
    ) else report_error("enable chain", int'($sampled(allow_mask)), int'($sampled(done)));

    a_slot_order: assert property (@(posedge ext_clk) disable iff (rst)
        (conv_any && chk_seq && have_prev) |-> (conv_slot == (prev_slot + 1) % NTI)
    ) else report_error(phase_name, ($sampled(prev_slot) + 1) % NTI, $sampled(conv_slot));

    a_ramp_step: assert property (@(posedge ext_clk) disable iff (rst)
        (conv_any && chk_seq && have_prev) |-> (conv_val == prev_val + exp_step - code_delta)
    ) else report_error(phase_name, $sampled(prev_val) + exp_step - $sampled(code_delta),
                        $sampled(conv_val));

    a_const_sign: assert property (@(posedge ext_clk) disable iff (rst)
        (conv_any && const_mode) |-> (conv_sign == exp_sign)
    ) else report_error("saturation sign", int'(exp_sign), int'($sampled(conv_sign)));

    a_const_mag: assert property (@(posedge ext_clk) disable iff (rst)
        (conv_any && const_mode) |-> (int'(conv_mag) == exp_mag)
    ) else report_error("saturation magnitude", exp_mag, int'($sampled(conv_mag)));

    task automatic report_error(input string name, input int expected, input int actual);
        $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic int sat_mag(input int x, input int off);
        int d;
        d = x - off;
        if (d < 0)
            d = -d;
        return (d > MAG_MAX) ? MAG_MAX : d;
    endfunction

    task automatic step_cycle();
        @(posedge ext_clk);
        #10;
        if (ramp_on)
            rx_in = rx_in + sample_t'(1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step_cycle();
    endtask

    task automatic wait_convs(input int n);
        int target;
        target = conv_count + n;
        while (conv_count < target)
            step_cycle();
    endtask

    task automatic wait_slot(input int k);
        int cnt0;
        do begin
            cnt0 = conv_count;
            step_cycle();
        end while (conv_count == cnt0 || last_slot != k);
    endtask

    task automatic start_segment(input ndiv_t nd, input logic byp);
        en_div = 1'b0;
        idle_cycles(6);             // drain tick to done
        rx_in      = sample_t'(-230);
        ramp_on    = 1'b1;
        ndiv       = nd;
        bypass_div = byp;
        exp_step   = byp ? 1 : int'(nd) + 1;
        idle_cycles(9);             // whole history on the new ramp
        clr_model = 1'b1;
        step_cycle();
        clr_model = 1'b0;
        chk_seq   = 1'b1;
        en_div    = 1'b1;
    endtask

    task automatic stop_segment();
        en_div = 1'b0;
        idle_cycles(6);
        chk_seq = 1'b0;
    endtask

    task automatic pulse_code(input int c);
        ctl_pi     = pi_code_t'(c);
        ctl_valid  = 1'b1;
        pend_model = c;
        step_cycle();
        ctl_valid = 1'b0;
    endtask

    task automatic apply_const(input int x, input int off);
        en_div = 1'b0;
        idle_cycles(6);
        ramp_on    = 1'b0;
        rx_in      = sample_t'(x);
        offset     = sample_t'(off);
        exp_sign   = (x - off >= 0);
        exp_mag    = sat_mag(x, off);
        bypass_div = 1'b1;
        idle_cycles(10);            // history settles on the constant
        const_mode = 1'b1;
        en_div     = 1'b1;
        wait_convs(NTI);
        en_div = 1'b0;
        idle_cycles(6);
        const_mode = 1'b0;
    endtask

    initial begin
        ndiv_t nd;
        int    cnt0;
        ext_clk    = 1'b0;
        rst        = 1'b1;
        rx_in      = '0;
        offset     = '0;
        ndiv       = '0;
        bypass_div = 1'b0;
        en_div     = 1'b0;
        ctl_pi     = '0;
        ctl_valid  = 1'b0;
        en_v2t     = 1'b0;
        en_slice   = '1;
        ramp_on    = 1'b0;
        clr_model  = 1'b0;
        chk_seq    = 1'b0;
        const_mode = 1'b0;
        allow_mask = '0;
        exp_step   = 1;
        pend_model = 0;
        exp_mag    = 0;
        exp_sign   = 1'b0;

        idle_cycles(4);
        rst = 1'b0;
        idle_cycles(4);

        // enable chain, first all slices then a cut at slice 5
        phase_name = "enable chain";
        en_v2t     = 1'b1;
        allow_mask = '1;
        idle_cycles(NTI + 2);
        start_segment(ndiv_t'(0), 1'b1);
        wait_convs(NTI);
        stop_segment();
        assert (first_slot == 0) else report_error("enable chain", 0, first_slot);
        en_slice    = '1;
        en_slice[5] = 1'b0;
        allow_mask  = NTI'((1 << 5) - 1);
        idle_cycles(NTI + 2);
        cnt0       = conv_count;
        bypass_div = 1'b1;
        en_div     = 1'b1;
        idle_cycles(4 * NTI);
        en_div = 1'b0;
        idle_cycles(6);
        assert (conv_count - cnt0 == 4 * 5)
            else report_error("enable chain", 4 * 5, conv_count - cnt0);
        en_slice   = '1;
        allow_mask = '1;
        idle_cycles(NTI + 2);

        phase_name = "round robin";
        offset     = sample_t'(17);
        for (int i = 0; i < 4; i++) begin
            nd = ndiv_t'($random(seed));
            start_segment(nd, 1'b0);
            wait_convs(2 * NTI);
            stop_segment();
        end
        start_segment(ndiv_t'(5), 1'b1);   // bypass ignores the ratio
        wait_convs(2 * NTI);
        stop_segment();

        // code change lands mid frame, applied from the next slot 0
        phase_name = "phase code";
        start_segment(ndiv_t'(2), 1'b0);
        wait_convs(NTI);
        wait_slot(2);
        pulse_code(5);
        wait_convs(2 * NTI);
        wait_slot(2);
        pulse_code(2);
        wait_convs(2 * NTI);
        stop_segment();

        phase_name = "saturation";
        apply_const(300, 20);
        apply_const(-400, 50);
        apply_const(10, 10);
        apply_const(-5, 0);
        apply_const(100, -100);
        apply_const(511, -512);
        apply_const(-512, 511);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/acore_pkg.sv
`default_nettype none

package acore_pkg;

    // slice output resolution
    localparam int Nadc = 8;

    // history depth of the sample-and-hold, one tap per phase code
    localparam int Nhist = 8;

    typedef logic signed [9:0] sample_t;    // pad voltage as one signed word
    typedef logic [Nadc-1:0]   mag_t;       // saturated slice magnitude
    typedef logic [2:0]        pi_code_t;   // selects history tap 0..7
    typedef logic [3:0]        slot_t;      // slice index, up to 16 slices
    typedef logic [3:0]        ndiv_t;      // divider ratio minus one

    // interpolator run state
    typedef enum logic {
        IDLE,
        RUN
    } pi_state_e;

endpackage

`default_nettype wire

//--- verilog/analog_core.sv
`timescale 1ns/1ns
`default_nettype none

module analog_core import acore_pkg::*; #(
    parameter int Nti = 8
) (
    input  wire logic     ext_clk_i,
    input  wire logic     rst_i,
    input  wire sample_t  rx_in_i,        // pad input, one word per cycle
    input  wire sample_t  offset_i,       // slice calibration offset
    input  wire ndiv_t    ndiv_i,
    input  wire logic     bypass_div_i,
    input  wire logic     en_div_i,
    input  wire pi_code_t ctl_pi_i,       // phase code from the digital core
    input  wire logic     ctl_valid_i,
    input  wire logic     en_v2t_i,       // head of the enable chain
    input  wire logic [Nti-1:0] en_slice_i,
    output mag_t          adder_out_o [Nti-1:0],
    output logic [Nti-1:0] sign_out_o,
    output logic [Nti-1:0] done_o
);

    logic           div_tick;
    logic           sample_stb;
    slot_t          slot;
    pi_code_t       code;
    sample_t        hold [Nti-1:0];
    logic [Nti-1:0] load;
    logic [Nti-1:0] en_sync_in;
    logic [Nti-1:0] en_sync_out;

    // sampling clock from the fast input clock
    input_divider input_divider_inst (
        .ext_clk_i    (ext_clk_i),
        .rst_i        (rst_i),
        .en_div_i     (en_div_i),
        .bypass_div_i (bypass_div_i),
        .ndiv_i       (ndiv_i),
        .div_tick_o   (div_tick)
    );

    // one interpolator for all slices
    phase_interpolator #(.Nti(Nti)) phase_interpolator_inst (
        .ext_clk_i    (ext_clk_i),
        .rst_i        (rst_i),
        .div_tick_i   (div_tick),
        .ctl_pi_i     (ctl_pi_i),
        .ctl_valid_i  (ctl_valid_i),
        .sample_stb_o (sample_stb),
        .slot_o       (slot),
        .code_o       (code)
    );

    snh #(.Nti(Nti)) snh_inst (
        .ext_clk_i    (ext_clk_i),
        .rst_i        (rst_i),
        .rx_in_i      (rx_in_i),
        .sample_stb_i (sample_stb),
        .slot_i       (slot),
        .code_i       (code),
        .hold_o       (hold),
        .load_o       (load)
    );

    // time-interleaved slices
    generate
        for (genvar k = 0; k < Nti; k++) begin : g_slice
            if (k == 0) begin : g_head
                assign en_sync_in[k] = en_v2t_i;
            end else begin : g_chain
                assign en_sync_in[k] = en_sync_out[k-1];    // previous slice releases this one
            end

            slice_adc slice_adc_inst (
                .ext_clk_i   (ext_clk_i),
                .rst_i       (rst_i),
                .hold_i      (hold[k]),
                .load_i      (load[k]),
                .offset_i    (offset_i),
                .en_slice_i  (en_slice_i[k]),
                .en_sync_i   (en_sync_in[k]),
                .en_sync_o   (en_sync_out[k]),
                .adder_out_o (adder_out_o[k]),
                .sign_out_o  (sign_out_o[k]),
                .done_o      (done_o[k])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/input_divider.sv
`timescale 1ns/1ns
`default_nettype none

module input_divider import acore_pkg::*; (
    input  wire logic  ext_clk_i,
    input  wire logic  rst_i,
    input  wire logic  en_div_i,
    input  wire logic  bypass_div_i,
    input  wire ndiv_t ndiv_i,
    output wire logic  div_tick_o
);

    ndiv_t cnt;     // counts down to the next tick

    // tick fires when the counter runs out, or every cycle in bypass
    assign div_tick_o = en_div_i & (bypass_div_i | (cnt == '0));

    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            cnt <= '0;
        end else if (!en_div_i || bypass_div_i) begin
            cnt <= '0;              // restart cleanly once divided mode resumes
        end else if (cnt == '0) begin
            cnt <= ndiv_i;          // reload, ratio is ndiv_i + 1
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // a divided tick is a single-cycle pulse, except for ratio one
    a_tick_pulse: assert property (
        @(posedge ext_clk_i) disable iff (rst_i)
        div_tick_o |=> (!div_tick_o || bypass_div_i || ndiv_i == '0)
    ) else $error("divider tick held high without bypass");

endmodule

`default_nettype wire

//--- verilog/phase_interpolator.sv
`timescale 1ns/1ns
`default_nettype none

module phase_interpolator import acore_pkg::*; #(
    parameter int Nti = 8
) (
    input  wire logic     ext_clk_i,
    input  wire logic     rst_i,
    input  wire logic     div_tick_i,
    input  wire pi_code_t ctl_pi_i,
    input  wire logic     ctl_valid_i,
    output logic          sample_stb_o,
    output slot_t         slot_o,
    output pi_code_t      code_o
);

    pi_state_e state;
    slot_t     slot_cnt;    // slot of the next tick once running
    slot_t     cur_slot;
    pi_code_t  pend_code;   // waits here for the next frame start

    // first tick after reset always opens a frame at slot 0
    assign cur_slot = (state == RUN) ? slot_cnt : '0;

    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            state        <= IDLE;
            sample_stb_o <= 1'b0;
            slot_o       <= '0;
            code_o       <= '0;
            pend_code    <= '0;
        end else begin
            sample_stb_o <= div_tick_i;
            if (ctl_valid_i)
                pend_code <= ctl_pi_i;
            if (div_tick_i) begin
                state  <= RUN;
                slot_o <= cur_slot;
                if (cur_slot == slot_t'(Nti - 1))
                    slot_cnt <= '0;     // wrap round robin
                else
                    slot_cnt <= cur_slot + 1'b1;
                // new code lands together with the slot-0 strobe
                if (cur_slot == '0)
                    code_o <= pend_code;
            end
        end
    end

    // a frame is sampled with one code from slot 0 to slot Nti-1
    a_code_at_frame: assert property (
        @(posedge ext_clk_i) disable iff (rst_i)
        $changed(code_o) |-> (sample_stb_o && slot_o == '0)
    ) else $error("phase code changed inside a frame");

endmodule

`default_nettype wire

//--- verilog/slice_adc.sv
`timescale 1ns/1ns
`default_nettype none

module slice_adc import acore_pkg::*; (
    input  wire logic    ext_clk_i,
    input  wire logic    rst_i,
    input  wire sample_t hold_i,
    input  wire logic    load_i,
    input  wire sample_t offset_i,
    input  wire logic    en_slice_i,
    input  wire logic    en_sync_i,
    output logic         en_sync_o,
    output mag_t         adder_out_o,
    output logic         sign_out_o,
    output logic         done_o
);

    localparam int DW = $bits(sample_t) + 1;

    logic signed [DW-1:0] diff;     // one extra bit so the subtraction cannot wrap
    logic        [DW-1:0] abs_diff;
    mag_t                 mag_sat;

    // offset correction
    assign diff = DW'(hold_i) - DW'(offset_i);

    // magnitude, then clip to the slice full scale
    assign abs_diff = diff[DW-1] ? DW'(-diff) : DW'(diff);
    assign mag_sat  = (abs_diff > DW'({Nadc{1'b1}})) ? {Nadc{1'b1}} : abs_diff[Nadc-1:0];

    // enable released one slice per cycle down the chain
    always_ff @(posedge ext_clk_i) begin
        if (rst_i)
            en_sync_o <= 1'b0;
        else
            en_sync_o <= en_sync_i & en_slice_i;
    end

    // conversion, samples on a disabled slice are dropped
    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            adder_out_o <= '0;
            sign_out_o  <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (load_i && en_sync_o) begin
                sign_out_o  <= ~diff[DW-1];     // 1 for zero or above
                adder_out_o <= mag_sat;
                done_o      <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/snh.sv
`timescale 1ns/1ns
`default_nettype none

module snh import acore_pkg::*; #(
    parameter int Nti = 8
) (
    input  wire logic     ext_clk_i,
    input  wire logic     rst_i,
    input  wire sample_t  rx_in_i,
    input  wire logic     sample_stb_i,
    input  wire slot_t    slot_i,
    input  wire pi_code_t code_i,
    output sample_t       hold_o [Nti-1:0],
    output logic [Nti-1:0] load_o
);

    sample_t hist [Nhist-1:0];  // hist[0] is the newest sample

    // input history line
    always_ff @(posedge ext_clk_i) begin
        hist[0] <= rx_in_i;
        for (int i = 1; i < Nhist; i++) begin
            hist[i] <= hist[i-1];
        end
    end

    // per-slice hold caps where a larger code picks an older tap
    always_ff @(posedge ext_clk_i) begin
        for (int k = 0; k < Nti; k++) begin
            if (sample_stb_i && slot_i == slot_t'(k))
                hold_o[k] <= hist[code_i];
        end
    end

    // load marks the freshly sampled slice one cycle after the strobe
    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            load_o <= '0;
        end else begin
            for (int k = 0; k < Nti; k++) begin
                load_o[k] <= sample_stb_i && (slot_i == slot_t'(k));
            end
        end
    end

    // only one slice is ever refreshed per cycle
    a_load_onehot: assert property (
        @(posedge ext_clk_i) disable iff (rst_i)
        $onehot0(load_o)
    ) else $error("more than one slice loaded at once");

endmodule

`default_nettype wire
